// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --assert -Wno-fatal -j 0
LINT_FLAGS = --lint-only -Wall
TOP        = tb_cpu
RTL_TOP    = cpu_top
FILELIST   = cpu_top.f
RTL_SRCS   = cpu_pkg.sv cpu_ifu.sv cpu_idu.sv cpu_exeu.sv cpu_wbu.sv cpu_top.sv
OBJ_DIR    = obj_dir
SIM_ARGS   = +verilator+error+limit+100
PASS_MSG   = No errors

.PHONY: run build lint clean

run: build
	out=$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)); echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

// ==== cpu_exeu.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_exeu import cpu_pkg::*; (
	input  wire         clk,
	input  wire         rst_n,
	input  wire         id_valid,
	input  wire  [31:0] pc,
	input  wire  [31:0] rs1_data,
	input  wire  [31:0] rs2_data,
	input  wire  [31:0] imm,
	input  alu_op_e     alu_op,
	input  wire         alu_src_a_pc,
	input  wire         alu_src_b_imm,
	input  br_kind_e    br_kind,
	input  wire         br_inv,
	input  res_sel_e    res_sel,
	input  wire  [4:0]  rd,
	input  wire         is_ebreak,
	output logic        exe_ready,
	output logic        exe_valid,
	output logic [31:0] pc_out,
	output logic [31:0] alu_result,
	output logic [31:0] link_addr,
	output logic [31:0] npc,
	output res_sel_e    res_sel_out,
	output logic [4:0]  rd_out,
	output logic        is_ebreak_out
);

	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [4:0]  shamt;
	logic [31:0] alu_d;
	logic        cond;
	logic        taken;
	logic [31:0] seq_pc;
	logic [31:0] npc_raw;

	assign op_a  = alu_src_a_pc ? pc : rs1_data;
	assign op_b  = alu_src_b_imm ? imm : rs2_data;
	assign shamt = op_b[4:0];

	always_comb begin
		case (alu_op)
			ALU_ADD:  alu_d = op_a + op_b;
			ALU_SUB:  alu_d = op_a - op_b;
			ALU_SLL:  alu_d = op_a << shamt;
			ALU_SLT:  alu_d = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: alu_d = {31'b0, op_a < op_b};
			ALU_XOR:  alu_d = op_a ^ op_b;
			ALU_SRL:  alu_d = op_a >> shamt;
			ALU_SRA:  alu_d = $unsigned($signed(op_a) >>> shamt);
			ALU_OR:   alu_d = op_a | op_b;
			ALU_AND:  alu_d = op_a & op_b;
			default:  alu_d = op_b;
		endcase
	end

	// Branch compare always works on the two source registers
	always_comb begin
		case (br_kind)
			BR_EQ:   cond = (rs1_data == rs2_data);
			BR_LT:   cond = $signed(rs1_data) < $signed(rs2_data);
			BR_LTU:  cond = rs1_data < rs2_data;
			default: cond = 1'b0;
		endcase
	end

	assign taken  = cond ^ br_inv;
	assign seq_pc = pc + 32'd4;

	always_comb begin
		case (br_kind)
			BR_JAL:               npc_raw = pc + imm;
			BR_JALR:              npc_raw = rs1_data + imm;
			BR_EQ, BR_LT, BR_LTU: npc_raw = taken ? pc + imm : seq_pc;
			default:              npc_raw = seq_pc;
		endcase
	end

	// Write-back drains every cycle
	assign exe_ready = !exe_valid;

	always_ff @(posedge clk) begin
		if (!rst_n)
			exe_valid <= 1'b0;
		else
			exe_valid <= id_valid && exe_ready;
	end

	always_ff @(posedge clk) begin
		if (id_valid && exe_ready) begin
			pc_out        <= pc;
			alu_result    <= alu_d;
			link_addr     <= seq_pc;
			npc           <= {npc_raw[31:2], 2'b00};
			res_sel_out   <= res_sel;
			rd_out        <= rd;
			is_ebreak_out <= is_ebreak;
		end
	end

endmodule

`default_nettype wire

// ==== cpu_idu.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_idu import cpu_pkg::*; (
	input  wire         clk,
	input  wire         rst_n,
	input  wire         if_valid,
	input  wire  [31:0] instr,
	input  wire  [31:0] pc_in,
	input  wire         exe_ready,
	input  wire         rf_we,
	input  wire  [4:0]  rf_waddr,
	input  wire  [31:0] rf_wdata,
	output logic        id_ready,
	output logic        id_valid,
	output logic [31:0] pc,
	output logic [31:0] rs1_data,
	output logic [31:0] rs2_data,
	output logic [31:0] imm,
	output alu_op_e     alu_op,
	output logic        alu_src_a_pc,
	output logic        alu_src_b_imm,
	output br_kind_e    br_kind,
	output logic        br_inv,
	output res_sel_e    res_sel,
	output logic [4:0]  rd,
	output logic        is_ebreak
);

	logic [31:0] ir;
	logic [31:0] regs [0:31];
	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [31:0] imm_i;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;

	function automatic alu_op_e alu_func(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	assign id_ready = !id_valid;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_valid <= 1'b0;
		end else if (if_valid && id_ready) begin
			id_valid <= 1'b1;
		end else if (id_valid && exe_ready) begin
			id_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (if_valid && id_ready) begin
			ir <= instr;
			pc <= pc_in;
		end
	end

	assign opcode = ir[6:0];
	assign funct3 = ir[14:12];
	assign rs1    = ir[19:15];
	assign rs2    = ir[24:20];
	assign rd     = ir[11:7];

	assign imm_i = {{20{ir[31]}}, ir[31:20]};
	assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
	assign imm_u = {ir[31:12], 12'b0};
	assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

	// Register file, x0 is never written
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'h0;
		end else if (rf_we && rf_waddr != 5'd0) begin
			regs[rf_waddr] <= rf_wdata;
		end
	end

	assign rs1_data = (rs1 == 5'd0) ? 32'h0 : regs[rs1];
	assign rs2_data = (rs2 == 5'd0) ? 32'h0 : regs[rs2];

	always_comb begin
		imm           = imm_i;
		alu_op        = ALU_ADD;
		alu_src_a_pc  = 1'b0;
		alu_src_b_imm = 1'b0;
		br_kind       = BR_NONE;
		br_inv        = 1'b0;
		res_sel       = RES_NONE;
		is_ebreak     = 1'b0;
		case (opcode)
			OPC_LUI: begin
				imm           = imm_u;
				alu_op        = ALU_PASS_B;
				alu_src_b_imm = 1'b1;
				res_sel       = RES_ALU;
			end
			OPC_AUIPC: begin
				imm           = imm_u;
				alu_src_a_pc  = 1'b1;
				alu_src_b_imm = 1'b1;
				res_sel       = RES_ALU;
			end
			OPC_JAL: begin
				imm     = imm_j;
				br_kind = BR_JAL;
				res_sel = RES_LINK;
			end
			OPC_JALR: begin
				br_kind = BR_JALR;
				res_sel = RES_LINK;
			end
			OPC_BRANCH: begin
				imm    = imm_b;
				br_inv = funct3[0];
				case (funct3[2:1])
					2'b00:   br_kind = BR_EQ;
					2'b10:   br_kind = BR_LT;
					2'b11:   br_kind = BR_LTU;
					default: br_kind = BR_NONE;
				endcase
			end
			OPC_OP_IMM: begin
				// Only the right shift uses bit 30 here
				alu_op        = alu_func(funct3, funct3 == 3'b101 && ir[30]);
				alu_src_b_imm = 1'b1;
				res_sel       = RES_ALU;
			end
			OPC_OP: begin
				alu_op  = alu_func(funct3, ir[30]);
				res_sel = RES_ALU;
			end
			default: begin
				is_ebreak = (ir == INSTR_EBREAK);
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== cpu_ifu.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_ifu #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input  wire         clk,
	input  wire         rst_n,
	input  wire         imem_valid,
	input  wire  [31:0] imem_data,
	input  wire         commit,
	input  wire  [31:0] npc,
	input  wire         halt,
	output logic        imem_req,
	output logic [31:0] imem_addr,
	output logic        if_valid,
	output logic [31:0] instr,
	output logic [31:0] pc,
	output logic        halted
);

	typedef enum logic [1:0] {
		S_REQ,
		S_WAIT,
		S_HALT
	} state_e;

	state_e      state;
	logic [31:0] pc_q;

	// PC only moves on commit, so it stays valid for the instruction in flight
	assign imem_addr = pc_q;
	assign pc        = pc_q;
	assign halted    = (state == S_HALT);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= S_REQ;
			imem_req <= 1'b0;
			if_valid <= 1'b0;
			pc_q     <= RESET_PC;
		end else begin
			if_valid <= 1'b0;
			case (state)
				S_REQ: begin
					if (imem_req && imem_valid) begin
						imem_req <= 1'b0;
						if_valid <= 1'b1;
						state    <= S_WAIT;
					end else begin
						imem_req <= 1'b1;
					end
				end
				S_WAIT: begin
					if (commit) begin
						pc_q <= {npc[31:2], 2'b00};
						if (halt) begin
							state <= S_HALT;
						end else begin
							state    <= S_REQ;
							imem_req <= 1'b1;
						end
					end
				end
				default: begin
					imem_req <= 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (imem_req && imem_valid)
			instr <= imem_data;
	end

endmodule

`default_nettype wire

// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	// Major opcodes
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	localparam logic [31:0] INSTR_EBREAK = 32'h00100073;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_e;

	// Conditional kinds are inverted by funct3[0]
	typedef enum logic [2:0] {
		BR_NONE,
		BR_EQ,
		BR_LT,
		BR_LTU,
		BR_JAL,
		BR_JALR
	} br_kind_e;

	typedef enum logic [1:0] {
		RES_ALU,
		RES_LINK,
		RES_NONE
	} res_sel_e;

endpackage

`default_nettype wire

// ==== cpu_top.f ====
cpu_pkg.sv
cpu_ifu.sv
cpu_idu.sv
cpu_exeu.sv
cpu_wbu.sv
cpu_top.sv
tb_cpu_chk.sv
tb_cpu.sv

// ==== cpu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_top import cpu_pkg::*; #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input  wire         clk,
	input  wire         rst_n,
	output logic        imem_req,
	output logic [31:0] imem_addr,
	input  wire         imem_valid,
	input  wire  [31:0] imem_data,
	output logic        retire_valid,
	output logic [31:0] retire_pc,
	output logic [4:0]  retire_rd,
	output logic [31:0] retire_wdata,
	output logic        retire_we,
	output logic        halted
);

	// IFU -> IDU
	logic        if_valid;
	logic [31:0] instr_fd;
	logic [31:0] pc_fd;
	// IDU -> EXEU
	logic        id_valid;
	logic        exe_ready;
	logic [31:0] pc_de;
	logic [31:0] rs1_data_de;
	logic [31:0] rs2_data_de;
	logic [31:0] imm_de;
	alu_op_e     alu_op_de;
	logic        alu_src_a_pc_de;
	logic        alu_src_b_imm_de;
	br_kind_e    br_kind_de;
	logic        br_inv_de;
	res_sel_e    res_sel_de;
	logic [4:0]  rd_de;
	logic        is_ebreak_de;
	// EXEU -> WBU
	logic        exe_valid;
	logic [31:0] pc_ew;
	logic [31:0] alu_result_ew;
	logic [31:0] link_addr_ew;
	logic [31:0] npc_ew;
	res_sel_e    res_sel_ew;
	logic [4:0]  rd_ew;
	logic        is_ebreak_ew;
	// WBU -> IDU, IFU
	logic        rf_we;
	logic [4:0]  rf_waddr;
	logic [31:0] rf_wdata;
	logic        commit;
	logic [31:0] npc_wf;
	logic        halt;

	cpu_ifu #(.RESET_PC(RESET_PC)) ifu0 (
		.clk(clk), .rst_n(rst_n),
		.imem_valid(imem_valid), .imem_data(imem_data),
		.commit(commit), .npc(npc_wf), .halt(halt),
		.imem_req(imem_req), .imem_addr(imem_addr),
		.if_valid(if_valid), .instr(instr_fd), .pc(pc_fd), .halted(halted)
	);

	cpu_idu idu0 (
		.clk(clk), .rst_n(rst_n),
		.if_valid(if_valid), .instr(instr_fd), .pc_in(pc_fd), .exe_ready(exe_ready),
		.rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
		.id_ready(), .id_valid(id_valid), .pc(pc_de),
		.rs1_data(rs1_data_de), .rs2_data(rs2_data_de), .imm(imm_de),
		.alu_op(alu_op_de), .alu_src_a_pc(alu_src_a_pc_de), .alu_src_b_imm(alu_src_b_imm_de),
		.br_kind(br_kind_de), .br_inv(br_inv_de), .res_sel(res_sel_de),
		.rd(rd_de), .is_ebreak(is_ebreak_de)
	);

	cpu_exeu exeu0 (
		.clk(clk), .rst_n(rst_n),
		.id_valid(id_valid), .pc(pc_de),
		.rs1_data(rs1_data_de), .rs2_data(rs2_data_de), .imm(imm_de),
		.alu_op(alu_op_de), .alu_src_a_pc(alu_src_a_pc_de), .alu_src_b_imm(alu_src_b_imm_de),
		.br_kind(br_kind_de), .br_inv(br_inv_de), .res_sel(res_sel_de),
		.rd(rd_de), .is_ebreak(is_ebreak_de),
		.exe_ready(exe_ready), .exe_valid(exe_valid), .pc_out(pc_ew),
		.alu_result(alu_result_ew), .link_addr(link_addr_ew), .npc(npc_ew),
		.res_sel_out(res_sel_ew), .rd_out(rd_ew), .is_ebreak_out(is_ebreak_ew)
	);

	cpu_wbu wbu0 (
		.clk(clk), .rst_n(rst_n),
		.exe_valid(exe_valid), .pc(pc_ew), .alu_result(alu_result_ew),
		.link_addr(link_addr_ew), .npc_in(npc_ew), .res_sel(res_sel_ew),
		.rd(rd_ew), .is_ebreak(is_ebreak_ew),
		.rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
		.commit(commit), .npc(npc_wf), .halt(halt),
		.retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
		.retire_wdata(retire_wdata), .retire_we(retire_we)
	);

endmodule

`default_nettype wire

// ==== cpu_wbu.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_wbu import cpu_pkg::*; (
	input  wire         clk,
	input  wire         rst_n,
	input  wire         exe_valid,
	input  wire  [31:0] pc,
	input  wire  [31:0] alu_result,
	input  wire  [31:0] link_addr,
	input  wire  [31:0] npc_in,
	input  res_sel_e    res_sel,
	input  wire  [4:0]  rd,
	input  wire         is_ebreak,
	output logic        rf_we,
	output logic [4:0]  rf_waddr,
	output logic [31:0] rf_wdata,
	output logic        commit,
	output logic [31:0] npc,
	output logic        halt,
	output logic        retire_valid,
	output logic [31:0] retire_pc,
	output logic [4:0]  retire_rd,
	output logic [31:0] retire_wdata,
	output logic        retire_we
);

	logic writes;
	logic ebreak_q;

	assign writes   = (res_sel != RES_NONE) && (rd != 5'd0) && !is_ebreak;
	assign rf_we    = exe_valid && writes;
	assign rf_waddr = rd;
	assign rf_wdata = (res_sel == RES_LINK) ? link_addr : alu_result;

	// Commit follows the register file write by one cycle
	assign commit = retire_valid;
	assign halt   = retire_valid && ebreak_q;

	always_ff @(posedge clk) begin
		if (!rst_n)
			retire_valid <= 1'b0;
		else
			retire_valid <= exe_valid;
	end

	always_ff @(posedge clk) begin
		if (exe_valid) begin
			retire_pc    <= pc;
			retire_rd    <= rd;
			retire_wdata <= rf_wdata;
			retire_we    <= writes;
			npc          <= npc_in;
			ebreak_q     <= is_ebreak;
		end
	end

endmodule

`default_nettype wire

// ==== tb_cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cpu;

	localparam logic [31:0] RESET_PC  = 32'h0;
	localparam int          NUM_INSTR = 2000;
	localparam int          RETIRE_LAT = 3;
	// Worst case is 10 cycles per instruction with a 4-cycle memory
	localparam int          WATCHDOG_CYCLES = (NUM_INSTR + 1) * 10 + 16 + 100;

	localparam logic [6:0]  LUI    = 7'b0110111;
	localparam logic [6:0]  AUIPC  = 7'b0010111;
	localparam logic [6:0]  JAL    = 7'b1101111;
	localparam logic [6:0]  JALR   = 7'b1100111;
	localparam logic [6:0]  BRANCH = 7'b1100011;
	localparam logic [6:0]  OP_IMM = 7'b0010011;
	localparam logic [6:0]  OP_REG = 7'b0110011;
	localparam logic [31:0] EBREAK = 32'h00100073;

	logic        clk = 1'b0;
	logic        rst_n = 1'b0;
	logic        imem_valid = 1'b0;
	logic [31:0] imem_data = 32'h0;
	logic        imem_req;
	logic [31:0] imem_addr;
	logic        retire_valid;
	logic [31:0] retire_pc;
	logic [4:0]  retire_rd;
	logic [31:0] retire_wdata;
	logic        retire_we;
	logic        halted;

	logic [31:0] mem [bit [31:0]];
	logic [31:0] shadow [0:31];
	logic [31:0] shadow_pc = RESET_PC;
	integer      seed = 83;
	int          fetched = 0;
	int          retired = 0;
	int          cycle = 0;
	int          xfer_cycle = 0;
	int          mem_delay = 0;
	logic        mem_busy = 1'b0;
	logic [31:0] word;
	logic        first_req_seen = 1'b0;
	logic        ebreak_retired = 1'b0;

	cpu_top #(.RESET_PC(RESET_PC)) dut0 (
		.clk(clk), .rst_n(rst_n),
		.imem_req(imem_req), .imem_addr(imem_addr),
		.imem_valid(imem_valid), .imem_data(imem_data),
		.retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
		.retire_wdata(retire_wdata), .retire_we(retire_we), .halted(halted)
	);

	bind cpu_top tb_cpu_chk chk0 (
		.clk(clk), .rst_n(rst_n), .imem_req(imem_req), .imem_addr(imem_addr),
		.imem_valid(imem_valid), .retire_valid(retire_valid), .halted(halted)
	);

	always #5 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic show_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		stop_on_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	// Branch and JAL offsets stay within +-256 bytes
	function automatic logic [31:0] random_instr();
		logic [31:0] r;
		logic [31:0] r2;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [11:0] imm12;
		logic [6:0]  f7;
		logic [12:0] boff;
		logic [20:0] joff;
		int          kind;
		kind = int'($unsigned($random(seed)) % 7);
		r    = $random(seed);
		r2   = $random(seed);
		rd   = r[4:0];
		rs1  = r[9:5];
		rs2  = r[14:10];
		f3   = r[17:15];
		boff = {{4{r[31]}}, r[31:24], 1'b0};
		joff = {{12{r[31]}}, r[31:24], 1'b0};
		case (kind)
			0: return {r2[31:12], rd, LUI};
			1: return {r2[31:12], rd, AUIPC};
			2: return {joff[20], joff[10:1], joff[11], joff[19:12], rd, JAL};
			3: return {r2[31:20], rs1, 3'b000, rd, JALR};
			4: begin
				// funct3 010 and 011 are not branches
				if (f3[2:1] == 2'b01)
					f3[2] = 1'b1;
				return {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], BRANCH};
			end
			5: begin
				if (f3 == 3'b001)
					imm12 = {7'b0, r2[24:20]};
				else if (f3 == 3'b101)
					imm12 = {1'b0, r[18], 5'b0, r2[24:20]};
				else
					imm12 = r2[31:20];
				return {imm12, rs1, f3, rd, OP_IMM};
			end
			default: begin
				f7 = ((f3 == 3'b000 || f3 == 3'b101) && r[18]) ? 7'b0100000 : 7'b0;
				return {f7, rs2, rs1, f3, rd, OP_REG};
			end
		endcase
	endfunction

	// Fetch 2001 is always the EBREAK, which also ends any loop
	task automatic load_word(input logic [31:0] addr, output logic [31:0] data);
		if (fetched >= NUM_INSTR)
			mem[addr] = EBREAK;
		else if (!mem.exists(addr))
			mem[addr] = random_instr();
		fetched++;
		data = mem[addr];
	endtask

	// Memory answers 0 to 4 cycles after it sees the request
	always @(posedge clk) begin
		if (!rst_n) begin
			imem_valid <= 1'b0;
			mem_busy = 1'b0;
		end else if (imem_valid) begin
			imem_valid <= 1'b0;
		end else if (imem_req) begin
			if (!mem_busy) begin
				mem_busy  = 1'b1;
				mem_delay = int'($unsigned($random(seed)) % 5);
			end
			if (mem_delay == 0) begin
				load_word(imem_addr, word);
				imem_data  <= word;
				imem_valid <= 1'b1;
				mem_busy = 1'b0;
			end else begin
				mem_delay = mem_delay - 1;
			end
		end
	end

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000:  return alt ? a - b : a + b;
			3'b001:  return a << b[4:0];
			3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011:  return (a < b) ? 32'd1 : 32'd0;
			3'b100:  return a ^ b;
			3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	// ISA model of one instruction, a and b are the rs1 and rs2 values
	function automatic void reference_step(input logic [31:0] ins, input logic [31:0] pc,
			input logic [31:0] a, input logic [31:0] b, output logic we,
			output logic [4:0] rd, output logic [31:0] wd, output logic [31:0] npc);
		logic [31:0] imm_i;
		logic [31:0] imm_b;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		logic [2:0]  f3;
		logic        taken;
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_u = {ins[31:12], 12'b0};
		imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		f3    = ins[14:12];
		rd    = ins[11:7];
		we    = 1'b0;
		wd    = 32'h0;
		npc   = pc + 32'd4;
		taken = 1'b0;
		case (ins[6:0])
			LUI: begin
				we = 1'b1;
				wd = imm_u;
			end
			AUIPC: begin
				we = 1'b1;
				wd = pc + imm_u;
			end
			JAL: begin
				we  = 1'b1;
				wd  = pc + 32'd4;
				npc = pc + imm_j;
			end
			JALR: begin
				we  = 1'b1;
				wd  = pc + 32'd4;
				npc = a + imm_i;
			end
			BRANCH: begin
				case (f3)
					3'b000:  taken = (a == b);
					3'b001:  taken = (a != b);
					3'b100:  taken = $signed(a) < $signed(b);
					3'b101:  taken = $signed(a) >= $signed(b);
					3'b110:  taken = a < b;
					3'b111:  taken = a >= b;
					default: taken = 1'b0;
				endcase
				if (taken)
					npc = pc + imm_b;
			end
			OP_IMM: begin
				we = 1'b1;
				wd = alu_ref(f3, f3 == 3'b101 && ins[30], a, imm_i);
			end
			OP_REG: begin
				we = 1'b1;
				wd = alu_ref(f3, ins[30], a, b);
			end
			default: we = 1'b0;
		endcase
		if (rd == 5'd0)
			we = 1'b0;
		npc[1:0] = 2'b00;
	endfunction

	task automatic check_retire();
		logic [31:0] ins;
		logic        exp_we;
		logic [4:0]  exp_rd;
		logic [31:0] exp_wd;
		logic [31:0] exp_npc;
		assert (!ebreak_retired)
			else stop_on_error("an instruction retired after the EBREAK");
		// retire_valid is set RETIRE_LAT edges after the transfer, seen one edge later
		assert (cycle == xfer_cycle + RETIRE_LAT + 1)
			else stop_on_error($sformatf("retire came %0d cycles after the transfer, not 3",
				cycle - xfer_cycle - 1));
		assert (retire_pc == shadow_pc)
			else show_mismatch("retire_pc", retire_pc, shadow_pc);
		ins = mem[shadow_pc];
		reference_step(ins, shadow_pc, shadow[ins[19:15]], shadow[ins[24:20]],
			exp_we, exp_rd, exp_wd, exp_npc);
		assert (retire_we == exp_we)
			else show_mismatch("retire_we", {31'b0, retire_we}, {31'b0, exp_we});
		if (exp_we) begin
			assert (retire_rd == exp_rd)
				else show_mismatch("retire_rd", {27'b0, retire_rd}, {27'b0, exp_rd});
			assert (retire_wdata == exp_wd)
				else show_mismatch("retire_wdata", retire_wdata, exp_wd);
			shadow[exp_rd] = exp_wd;
		end
		shadow_pc = exp_npc;
		retired++;
		if (ins == EBREAK)
			ebreak_retired = 1'b1;
	endtask

	always @(posedge clk) begin
		if (rst_n) begin
			assert (dut0.chk0.fail_count == 0)
				else stop_on_error("a protocol assertion in the checker failed");
			if (imem_req && !first_req_seen) begin
				first_req_seen = 1'b1;
				assert (imem_addr == RESET_PC)
					else show_mismatch("imem_addr", imem_addr, RESET_PC);
			end
			if (imem_req && imem_valid) begin
				xfer_cycle = cycle;
				// Fetch address must follow the ISA program counter
				assert (imem_addr == shadow_pc)
					else show_mismatch("imem_addr", imem_addr, shadow_pc);
			end
			if (retire_valid)
				check_retire();
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * 10);
		stop_on_error("timeout, the core never halted");
	end

	initial begin
		for (int i = 0; i < 32; i++)
			shadow[i] = 32'h0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		wait (ebreak_retired);
		@(posedge clk);
		assert (halted)
			else stop_on_error("halted did not rise after the EBREAK retired");
		repeat (20) begin
			@(posedge clk);
			assert (halted && !imem_req)
				else stop_on_error("the core left the halted state or made a request");
		end
		assert (retired == NUM_INSTR + 1)
			else stop_on_error($sformatf("%0d instructions retired, not %0d", retired,
				NUM_INSTR + 1));
		if (dut0.chk0.fail_count == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("Errors found");
			$fatal(1, "protocol assertions failed");
		end
	end

endmodule

`default_nettype wire

// ==== tb_cpu_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_chk (
	input wire        clk,
	input wire        rst_n,
	input wire        imem_req,
	input wire [31:0] imem_addr,
	input wire        imem_valid,
	input wire        retire_valid,
	input wire        halted
);

	// Read by the testbench each cycle
	int fail_count = 0;

	// Request holds with a fixed address until the memory answers
	req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		imem_req && !imem_valid |=> imem_req && $stable(imem_addr))
	else begin
		fail_count++;
		$error("imem_req dropped or imem_addr moved before imem_valid");
	end

	retire_single: assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid |=> !retire_valid)
	else begin
		fail_count++;
		$error("retire_valid high for two cycles");
	end

	halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		halted |-> !imem_req)
	else begin
		fail_count++;
		$error("imem_req raised while halted");
	end

endmodule

`default_nettype wire
